/* run_sim.sh */
#!/bin/sh
# Builds the fetch path testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_fetch_bypass \
  -o sim_fetch_bypass

status=0
./obj_dir/sim_fetch_bypass > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

/* source/fetch_bypass_pkg.sv */
// ##############################
// Widths, types and default sizes shared by the fetch path RTL.
// Modules import it inside their body.
// ##############################

package fetch_bypass_pkg;

  // Address and data widths of the fetch ports
  localparam int FETCH_AW = 32;
  localparam int FETCH_DW = 32;

  // One refill line is read as several Wishbone beats
  localparam int LINE_WIDTH = 128;
  localparam int FILL_DW = 32;

  localparam int LINE_ALIGN = $clog2(LINE_WIDTH / 8);
  localparam int FETCH_ALIGN = $clog2(FETCH_DW / 8);
  localparam int BEATS_PER_LINE = LINE_WIDTH / FILL_DW;

  // Sizes used by the top level unless overridden
  localparam int DEFAULT_NR_FETCH_PORTS = 2;
  localparam int DEFAULT_QUEUE_DEPTH = 4;

  typedef logic [FETCH_AW-1:0] addr_t;
  typedef logic [FETCH_DW-1:0] fetch_data_t;
  typedef logic [FILL_DW-1:0] fill_data_t;
  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

endpackage

/* source/fetch_bypass_top.sv */
// ##############################
// Uncached instruction fetch path. Several fetch ports share one
// Wishbone read bus through an arbiter, a request queue and a refill master.
// ##############################
`timescale 1ns/10ps

module fetch_bypass_top #(
  parameter int NR_FETCH_PORTS = fetch_bypass_pkg::DEFAULT_NR_FETCH_PORTS,
  parameter int QUEUE_DEPTH = fetch_bypass_pkg::DEFAULT_QUEUE_DEPTH,
  localparam int PORT_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1
) (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  logic [NR_FETCH_PORTS-1:0]                         inst_valid_i,
  input  fetch_bypass_pkg::addr_t [NR_FETCH_PORTS-1:0]      inst_addr_i,
  output logic [NR_FETCH_PORTS-1:0]                         inst_ready_o,
  output fetch_bypass_pkg::fetch_data_t [NR_FETCH_PORTS-1:0] inst_data_o,
  output logic [NR_FETCH_PORTS-1:0]                         inst_error_o,
  output logic                                              wb_cyc_o,
  output logic                                              wb_stb_o,
  output fetch_bypass_pkg::addr_t                           wb_adr_o,
  input  fetch_bypass_pkg::fill_data_t                      wb_dat_i,
  input  logic                                              wb_ack_i,
  input  logic                                              wb_err_i
);
  import fetch_bypass_pkg::*;

  logic [NR_FETCH_PORTS-1:0]  req;
  addr_t [NR_FETCH_PORTS-1:0] req_addr;
  logic [NR_FETCH_PORTS-1:0]  grant;
  logic                       push;
  logic [PORT_W-1:0]          push_port;
  addr_t                      push_addr;
  logic                       queue_full;
  logic                       queue_not_empty;
  logic [PORT_W-1:0]          head_port;
  addr_t                      head_addr;
  logic                       pop;
  logic                       rsp_valid;
  logic [PORT_W-1:0]          rsp_port;
  line_t                      rsp_line;
  logic                       rsp_error;

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_port
    fetch_port_ctrl #(
      .NR_FETCH_PORTS(NR_FETCH_PORTS),
      .PORT_ID(i)
    ) u_port (
      .clk_i(clk_i),
      .arst_n_i(arst_n_i),
      .inst_valid_i(inst_valid_i[i]),
      .inst_addr_i(inst_addr_i[i]),
      .inst_ready_o(inst_ready_o[i]),
      .inst_data_o(inst_data_o[i]),
      .inst_error_o(inst_error_o[i]),
      .req_o(req[i]),
      .req_addr_o(req_addr[i]),
      .grant_i(grant[i]),
      .rsp_valid_i(rsp_valid),
      .rsp_port_i(rsp_port),
      .rsp_line_i(rsp_line),
      .rsp_error_i(rsp_error)
    );
  end

  request_arbiter #(
    .NR_FETCH_PORTS(NR_FETCH_PORTS)
  ) u_arbiter (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .req_i(req),
    .req_addr_i(req_addr),
    .queue_full_i(queue_full),
    .grant_o(grant),
    .push_o(push),
    .push_port_o(push_port),
    .push_addr_o(push_addr)
  );

  request_queue #(
    .NR_FETCH_PORTS(NR_FETCH_PORTS),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_queue (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .push_i(push),
    .push_port_i(push_port),
    .push_addr_i(push_addr),
    .pop_i(pop),
    .full_o(queue_full),
    .not_empty_o(queue_not_empty),
    .head_port_o(head_port),
    .head_addr_o(head_addr)
  );

  line_refill_wb #(
    .NR_FETCH_PORTS(NR_FETCH_PORTS)
  ) u_refill (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .not_empty_i(queue_not_empty),
    .head_port_i(head_port),
    .head_addr_i(head_addr),
    .pop_o(pop),
    .wb_cyc_o(wb_cyc_o),
    .wb_stb_o(wb_stb_o),
    .wb_adr_o(wb_adr_o),
    .wb_dat_i(wb_dat_i),
    .wb_ack_i(wb_ack_i),
    .wb_err_i(wb_err_i),
    .rsp_valid_o(rsp_valid),
    .rsp_port_o(rsp_port),
    .rsp_line_o(rsp_line),
    .rsp_error_o(rsp_error)
  );

endmodule

/* source/fetch_port_ctrl.sv */
// ##############################
// Fetch port controller. Turns a held fetch request into a line request,
// waits for the tagged line and presents the selected word for one cycle.
// ##############################
`timescale 1ns/10ps

module fetch_port_ctrl #(
  parameter int NR_FETCH_PORTS = fetch_bypass_pkg::DEFAULT_NR_FETCH_PORTS,
  parameter int PORT_ID = 0,
  localparam int PORT_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          inst_valid_i,
  input  fetch_bypass_pkg::addr_t       inst_addr_i,
  output logic                          inst_ready_o,
  output fetch_bypass_pkg::fetch_data_t inst_data_o,
  output logic                          inst_error_o,
  output logic                          req_o,
  output fetch_bypass_pkg::addr_t       req_addr_o,
  input  logic                          grant_i,
  input  logic                          rsp_valid_i,
  input  logic [PORT_W-1:0]             rsp_port_i,
  input  fetch_bypass_pkg::line_t       rsp_line_i,
  input  logic                          rsp_error_i
);
  import fetch_bypass_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RSP,
    PRESENT
  } state_e;

  state_e                            state_q;
  state_e                            state_d;
  logic [LINE_ALIGN-FETCH_ALIGN-1:0] word_off;
  logic                              rsp_hit;
  fetch_data_t                       sel_word;

  // The requester holds the address until ready, so it can be used directly
  assign req_addr_o = {inst_addr_i[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign word_off = inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN];
  assign sel_word = rsp_line_i[word_off*FETCH_DW +: FETCH_DW];

  // Responses are broadcast to all ports, only our own tag is taken
  assign rsp_hit = rsp_valid_i && (rsp_port_i == PORT_W'(PORT_ID));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (inst_valid_i) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        if (grant_i) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (rsp_hit) begin
          state_d = PRESENT;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign req_o = (state_q == REQUEST);
  assign inst_ready_o = (state_q == PRESENT);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word and error are held for the single present cycle
  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_RSP && rsp_hit) begin
      inst_data_o <= sel_word;
      inst_error_o <= rsp_error_i;
    end
  end

endmodule

/* source/line_refill_wb.sv */
// ##############################
// Wishbone classic read master. Takes one queued request at a time,
// reads the whole line beat by beat and broadcasts it with the port tag.
// ##############################
`timescale 1ns/10ps

module line_refill_wb #(
  parameter int NR_FETCH_PORTS = fetch_bypass_pkg::DEFAULT_NR_FETCH_PORTS,
  localparam int PORT_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         not_empty_i,
  input  logic [PORT_W-1:0]            head_port_i,
  input  fetch_bypass_pkg::addr_t      head_addr_i,
  output logic                         pop_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output fetch_bypass_pkg::addr_t      wb_adr_o,
  input  fetch_bypass_pkg::fill_data_t wb_dat_i,
  input  logic                         wb_ack_i,
  input  logic                         wb_err_i,
  output logic                         rsp_valid_o,
  output logic [PORT_W-1:0]            rsp_port_o,
  output fetch_bypass_pkg::line_t      rsp_line_o,
  output logic                         rsp_error_o
);
  import fetch_bypass_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    RESPOND
  } state_e;

  state_e    state_q;
  beat_cnt_t beat_q;
  logic      err_q;
  addr_t     line_addr_q;
  line_t     line_q;
  logic      last_beat;

  assign pop_o = (state_q == IDLE) && not_empty_i;
  assign last_beat = (beat_q == beat_cnt_t'(BEATS_PER_LINE - 1));

  // Cycle stays up for all beats, strobe is never dropped between beats
  assign wb_cyc_o = (state_q == BUS);
  assign wb_stb_o = (state_q == BUS);
  assign wb_adr_o = line_addr_q + (addr_t'(beat_q) << $clog2(FILL_DW / 8));

  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_line_o = line_q;
  assign rsp_error_o = err_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      beat_q <= '0;
      err_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (pop_o) begin
            state_q <= BUS;
            beat_q <= '0;
            err_q <= 1'b0;
          end
        end
        BUS: begin
          // An error ends the line early and skips the remaining beats
          if (wb_err_i) begin
            err_q <= 1'b1;
            state_q <= RESPOND;
          end else if (wb_ack_i) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= RESPOND;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      line_addr_q <= head_addr_i;
      rsp_port_o <= head_port_i;
    end
    if (state_q == BUS && wb_ack_i && !wb_err_i) begin
      line_q[beat_q*FILL_DW +: FILL_DW] <= wb_dat_i;
    end
  end

endmodule

/* source/request_arbiter.sv */
// ##############################
// Round-robin arbiter between the port line requests.
// The winner is pushed into the request queue in the grant cycle.
// ##############################
`timescale 1ns/10ps

module request_arbiter #(
  parameter int NR_FETCH_PORTS = fetch_bypass_pkg::DEFAULT_NR_FETCH_PORTS,
  localparam int PORT_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1
) (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic [NR_FETCH_PORTS-1:0]                    req_i,
  input  fetch_bypass_pkg::addr_t [NR_FETCH_PORTS-1:0] req_addr_i,
  input  logic                                         queue_full_i,
  output logic [NR_FETCH_PORTS-1:0]                    grant_o,
  output logic                                         push_o,
  output logic [PORT_W-1:0]                            push_port_o,
  output fetch_bypass_pkg::addr_t                      push_addr_o
);
  import fetch_bypass_pkg::*;

  // Index of the port granted most recently
  logic [PORT_W-1:0] last_q;

  // Search starts one past the last winner and wraps around
  always_comb begin
    int unsigned cand;
    grant_o = '0;
    push_o = 1'b0;
    push_port_o = '0;
    for (int unsigned k = 1; k <= NR_FETCH_PORTS; k++) begin
      cand = (int'(last_q) + k) % NR_FETCH_PORTS;
      if (!push_o && req_i[cand] && !queue_full_i) begin
        grant_o[cand] = 1'b1;
        push_o = 1'b1;
        push_port_o = PORT_W'(cand);
      end
    end
    push_addr_o = req_addr_i[push_port_o];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= PORT_W'(NR_FETCH_PORTS - 1);
    end else if (push_o) begin
      last_q <= push_port_o;
    end
  end

endmodule

/* source/request_queue.sv */
// ##############################
// Request FIFO between the arbiter and the refill master.
// Holds port index and line address in grant order.
// ##############################
`timescale 1ns/10ps

module request_queue #(
  parameter int NR_FETCH_PORTS = fetch_bypass_pkg::DEFAULT_NR_FETCH_PORTS,
  parameter int QUEUE_DEPTH = fetch_bypass_pkg::DEFAULT_QUEUE_DEPTH,
  localparam int PORT_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    push_i,
  input  logic [PORT_W-1:0]       push_port_i,
  input  fetch_bypass_pkg::addr_t push_addr_i,
  input  logic                    pop_i,
  output logic                    full_o,
  output logic                    not_empty_o,
  output logic [PORT_W-1:0]       head_port_o,
  output fetch_bypass_pkg::addr_t head_addr_o
);
  import fetch_bypass_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [PORT_W-1:0] port_mem [QUEUE_DEPTH];
  addr_t             addr_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o = (count_q == CNT_W'(QUEUE_DEPTH));
  assign not_empty_o = (count_q != '0);
  assign head_port_o = port_mem[rd_ptr_q];
  assign head_addr_o = addr_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leave the occupancy unchanged
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      port_mem[wr_ptr_q] <= push_port_i;
      addr_mem[wr_ptr_q] <= push_addr_i;
    end
  end

endmodule

/* src.f */
source/fetch_bypass_pkg.sv
source/fetch_port_ctrl.sv
source/request_arbiter.sv
source/request_queue.sv
source/line_refill_wb.sv
source/fetch_bypass_top.sv
verification/fetch_bypass_chk.sv
verification/tb_fetch_bypass.sv

/* verification/fetch_bypass_chk.sv */
// ##############################
// Protocol checks on the Wishbone master and the fetch ready pulse.
// Bound into the fetch path top level.
// ##############################
`timescale 1ns/10ps

module fetch_bypass_chk #(
  parameter int NR_FETCH_PORTS = fetch_bypass_pkg::DEFAULT_NR_FETCH_PORTS
) (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    wb_cyc_i,
  input logic                    wb_stb_i,
  input fetch_bypass_pkg::addr_t wb_adr_i,
  input logic                    wb_ack_i,
  input logic                    wb_err_i,
  input logic [NR_FETCH_PORTS-1:0] inst_ready_i
);

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i |-> wb_cyc_i)
    else $error("Wishbone stb high without cyc");

  // A pending beat keeps stb up with the same address
  a_adr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i && !wb_ack_i && !wb_err_i |=> wb_stb_i && $stable(wb_adr_i))
    else $error("Wishbone address or stb changed before ack or err");

  a_cyc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_cyc_i && !wb_ack_i && !wb_err_i |=> wb_cyc_i)
    else $error("Wishbone cyc dropped without ack or err");

  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    |inst_ready_i |=> ((inst_ready_i & $past(inst_ready_i)) == '0))
    else $error("Fetch ready held for more than one cycle");

endmodule

bind fetch_bypass_top fetch_bypass_chk #(
  .NR_FETCH_PORTS(NR_FETCH_PORTS)
) u_chk (
  .clk_i(clk_i),
  .arst_n_i(arst_n_i),
  .wb_cyc_i(wb_cyc_o),
  .wb_stb_i(wb_stb_o),
  .wb_adr_i(wb_adr_o),
  .wb_ack_i(wb_ack_i),
  .wb_err_i(wb_err_i),
  .inst_ready_i(inst_ready_o)
);

/* verification/fetch_input.txt */
# Columns: test port address(hex) expected_word(hex) expected_error
# Lines with one test number run together, each port takes its lines in order
1 0 00001000 5a5a1000 0
1 0 00001004 5a5a1004 0
1 0 00001008 5a5a1008 0
1 0 0000100c 5a5a100c 0
2 0 00002010 5a5a2010 0
2 1 00003024 5a5a3024 0
3 0 00004000 5a5a4000 0
3 1 00005008 5a5a5008 0
3 0 0000400c 5a5a400c 0
3 1 00006034 5a5a6034 0
3 0 00007018 5a5a7018 0
3 1 00005004 5a5a5004 0
4 1 f0000010 00000000 1
4 1 00008028 5a5a8028 0

/* verification/tb_fetch_bypass.sv */
// ##############################
// Testbench for the fetch path. Reads fetches from the stimulus file,
// models a Wishbone memory with random ack delay and checks each word.
// ##############################
`timescale 1ns/10ps

module tb_fetch_bypass;
  import fetch_bypass_pkg::*;

  localparam int NR_PORTS = DEFAULT_NR_FETCH_PORTS;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY = 10;
  localparam int CYCLES_PER_LINE = 200;

  logic                          clk;
  logic                          arst_n;
  logic [NR_PORTS-1:0]           inst_valid;
  addr_t [NR_PORTS-1:0]          inst_addr;
  logic [NR_PORTS-1:0]           inst_ready;
  fetch_data_t [NR_PORTS-1:0]    inst_data;
  logic [NR_PORTS-1:0]           inst_error;
  logic                          wb_cyc;
  logic                          wb_stb;
  addr_t                         wb_adr;
  fill_data_t                    wb_dat;
  logic                          wb_ack;
  logic                          wb_err;

  // One entry per file line
  int          test_q [$];
  int          port_q [$];
  addr_t       addr_q [$];
  fetch_data_t data_q [$];
  logic        err_q [$];
  int          n_lines = 0;
  int          errors = 0;
  int          ready_seen [NR_PORTS];
  logic [31:0] rand_state;

  fetch_bypass_top dut0 (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .inst_valid_i(inst_valid),
    .inst_addr_i(inst_addr),
    .inst_ready_o(inst_ready),
    .inst_data_o(inst_data),
    .inst_error_o(inst_error),
    .wb_cyc_o(wb_cyc),
    .wb_stb_o(wb_stb),
    .wb_adr_o(wb_adr),
    .wb_dat_i(wb_dat),
    .wb_ack_i(wb_ack),
    .wb_err_i(wb_err)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The memory model answers each stb after 0 to 3 wait cycles
  initial begin
    int delay_left;
    wb_dat = '0;
    wb_ack = 1'b0;
    wb_err = 1'b0;
    rand_state = 32'heaf8_c70b;
    delay_left = -1;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      wb_ack = 1'b0;
      wb_err = 1'b0;
      if (wb_stb) begin
        if (delay_left < 0) begin
          rand_state = lcg_next(rand_state);
          delay_left = int'(rand_state[17:16]);
        end
        if (delay_left == 0) begin
          // Nothing is mapped in the top region of the address space
          if (wb_adr >= 32'hF000_0000) begin
            wb_err = 1'b1;
          end else begin
            wb_dat = wb_adr ^ 32'h5A5A_0000;
            wb_ack = 1'b1;
          end
        end
        delay_left = delay_left - 1;
      end
    end
  end

  // Every ready pulse is counted in the middle of its cycle
  initial begin
    for (int i = 0; i < NR_PORTS; i++) begin
      ready_seen[i] = 0;
    end
    forever begin
      @(negedge clk);
      for (int i = 0; i < NR_PORTS; i++) begin
        if (inst_ready[i]) begin
          ready_seen[i]++;
        end
      end
    end
  end

  initial begin
    wait (n_lines > 0);
    #(n_lines * CYCLES_PER_LINE * CLK_PERIOD);
    $display("Timeout: the run took longer than %0d cycles", n_lines * CYCLES_PER_LINE);
    $display("Verification failed");
    $finish;
  end

  // Holds one request until ready, checks the word and the single pulse
  task automatic fetch_word(input int p, input addr_t addr, input fetch_data_t exp_data,
                            input logic exp_err);
    inst_addr[p] = addr;
    inst_valid[p] = 1'b1;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (!inst_ready[p]);
    assert (inst_error[p] === exp_err) else begin
      $display("[FAIL] %0d ns: port %0d addr %h error %b, expected %b",
               $time, p, addr, inst_error[p], exp_err);
      errors++;
    end
    if (!exp_err) begin
      assert (inst_data[p] === exp_data) else begin
        $display("[FAIL] %0d ns: port %0d addr %h data %h, expected %h",
                 $time, p, addr, inst_data[p], exp_data);
        errors++;
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    assert (!inst_ready[p]) else begin
      $display("[FAIL] %0d ns: port %0d ready stayed high a second cycle", $time, p);
      errors++;
    end
    inst_valid[p] = 1'b0;
  endtask

  task automatic issue_port_fetches(input int p, input int first, input int last);
    for (int i = first; i <= last; i++) begin
      if (port_q[i] == p) begin
        fetch_word(p, addr_q[i], data_q[i], err_q[i]);
      end
    end
  endtask

  task automatic check_reset_idle();
    repeat (5) begin
      @(posedge clk);
      #DRIVE_DLY;
      assert (inst_ready === '0 && wb_cyc === 1'b0) else begin
        $display("[FAIL] %0d ns: ready %b or cyc %b active before any request",
                 $time, inst_ready, wb_cyc);
        errors++;
      end
    end
  endtask

  initial begin
    int          fd;
    int          t;
    int          p;
    int          e;
    addr_t       a;
    fetch_data_t d;
    string       line_s;
    int          idx;
    int          first;
    int          last;
    int          err_before;
    int          tests_run;
    int          tests_failed;
    int          seen_before [NR_PORTS];
    int          n_exp;
    arst_n = 1'b0;
    inst_valid = '0;
    inst_addr = '0;
    tests_run = 0;
    tests_failed = 0;
    fd = $fopen("verification/fetch_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verification/fetch_input.txt");
      $display("Verification failed");
      $finish;
    end
    while (!$feof(fd)) begin
      line_s = "";
      void'($fgets(line_s, fd));
      if ($sscanf(line_s, "%d %d %h %h %d", t, p, a, d, e) == 5) begin
        test_q.push_back(t);
        port_q.push_back(p);
        addr_q.push_back(a);
        data_q.push_back(d);
        err_q.push_back(e != 0);
      end
    end
    $fclose(fd);
    n_lines = test_q.size();

    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;

    check_reset_idle();
    tests_run++;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("Test 0 (idle after reset): %s", (errors == 0) ? "PASS" : "FAIL");

    // Lines with one test number run together, each port in file order
    idx = 0;
    while (idx < n_lines) begin
      first = idx;
      last = idx;
      while (last + 1 < n_lines && test_q[last + 1] == test_q[first]) begin
        last++;
      end
      err_before = errors;
      for (int q = 0; q < NR_PORTS; q++) begin
        automatic int pq = q;
        seen_before[q] = ready_seen[q];
        fork
          issue_port_fetches(pq, first, last);
        join_none
      end
      wait fork;
      // Each port must see exactly one pulse per fetch of this test
      for (int q = 0; q < NR_PORTS; q++) begin
        n_exp = 0;
        for (int i = first; i <= last; i++) begin
          if (port_q[i] == q) begin
            n_exp++;
          end
        end
        assert (ready_seen[q] - seen_before[q] == n_exp) else begin
          $display("[FAIL] %0d ns: port %0d gave %0d ready pulses, expected %0d",
                   $time, q, ready_seen[q] - seen_before[q], n_exp);
          errors++;
        end
      end
      tests_run++;
      if (errors != err_before) begin
        tests_failed++;
      end
      $display("Test %0d (%0d fetches): %s", test_q[first], last - first + 1,
               (errors == err_before) ? "PASS" : "FAIL");
      idx = last + 1;
    end

    $display("Tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (n_lines == 0 || errors != 0) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  end

endmodule
